//--- include/agu_macros.svh
// AGU widths; only XLEN 32 with four byte lanes is supported by the lane and mask logic
`ifndef AGU_MACROS_SVH
`define AGU_MACROS_SVH

// Data word width
`define AGU_XLEN 32

// Address width, equal to XLEN
`define AGU_ADDR_W 32

// Bytes per data word
`define AGU_LANES 4

`endif

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module agu_tb -o agu_sim
out=$(./obj_dir/agu_sim 2>&1) || true
echo "$out"
grep -q '^\*\* PASS \*\*$' <<< "$out"

//--- sim.f
+incdir+include
verilog/mem_pkg.sv
verilog/agu_pkg.sv
verilog/agu_op_if.sv
verilog/agu_exec_if.sv
verilog/agu_decode.sv
verilog/agu_execute.sv
verilog/agu_result.sv
verilog/agu_top.sv
test/agu_assertions.sv
test/agu_tb.sv

//--- test/agu_assertions.sv
// Watches agu_top ports only; assumes issue fields held until in_ready and XLEN 32
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_assertions (
  input logic                   clk, rst_n, in_valid, in_ready, out_valid, out_ready,
  input logic [`AGU_XLEN-1:0]   in_rs1, in_rs2, in_imm, cmd_wdata, out_wdat,
  input agu_pkg::agu_info_t     in_info,
  input logic                   out_misalgn, out_err, out_ld, out_stamo, out_buserr,
  input logic                   cmd_valid, cmd_ready, cmd_read, cmd_lock, cmd_usign,
  input logic [`AGU_ADDR_W-1:0] cmd_addr, out_badaddr,
  input mem_pkg::mem_size_t     cmd_size,
  input logic [`AGU_LANES-1:0]  cmd_wmask
);
  import agu_pkg::*;
  import mem_pkg::*;

  logic                  is_amo;
  logic                  is_ldst;
  logic                  is_stamo;
  logic                  mis;
  mem_size_t             sz;
  logic [`AGU_XLEN-1:0]  ea;
  logic [`AGU_XLEN-1:0]  exp_data;
  logic [`AGU_LANES-1:0] exp_mask;

  // Reference address, alignment and lane pattern
  always_comb begin
    is_amo   = (in_info.kind == kind_amo);
    is_ldst  = (in_info.kind == kind_load) || (in_info.kind == kind_store);
    is_stamo = (in_info.kind == kind_store) || is_amo;
    sz       = is_amo ? size_word : in_info.body.ls.size;
    ea       = in_rs1 + (is_amo ? 32'd0 : in_imm);
    mis      = (sz == size_half) ? ea[0] : (sz == size_word) ? (ea[1:0] != 2'b00) : 1'b0;
    case (sz)
      size_byte: begin
        exp_data = {4{in_rs2[7:0]}};
        exp_mask = 4'b0001 << ea[1:0];
      end
      size_half: begin
        exp_data = {2{in_rs2[15:0]}};
        exp_mask = ea[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        exp_data = in_rs2;
        exp_mask = 4'b1111;
      end
    endcase
  end

  //////////////////////////////
  // Same-cycle load/store path
  //////////////////////////////
  a_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && is_ldst && cmd_valid) |-> (cmd_addr == ea && cmd_size == sz))
    else $error("FAILED %0t cmd_addr exp %h got %h, cmd_size exp %0d got %0d",
                $time, ea, cmd_addr, sz, cmd_size);
  a_kind: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && is_ldst && cmd_valid) |-> (cmd_read == (in_info.kind == kind_load)
      && !cmd_lock && cmd_usign == in_info.body.ls.usign))
    else $error("FAILED %0t cmd_read exp %b got %b, cmd_lock exp 0 got %b, cmd_usign exp %b got %b",
                $time, in_info.kind == kind_load, cmd_read, cmd_lock,
                in_info.body.ls.usign, cmd_usign);
  a_hs: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && is_ldst && !mis) |-> (cmd_valid == out_ready && out_valid == cmd_ready
      && in_ready == (cmd_ready && out_ready)))
    else $error("FAILED %0t cmd_valid exp %b got %b, out_valid exp %b got %b, in_ready exp %b got %b",
                $time, out_ready, cmd_valid, cmd_ready, out_valid,
                cmd_ready && out_ready, in_ready);
  a_store: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_valid && in_info.kind == kind_store) |-> (cmd_wdata == exp_data && cmd_wmask == exp_mask))
    else $error("FAILED %0t cmd_wmask exp %h got %h, cmd_wdata exp %h got %h",
                $time, exp_mask, cmd_wmask, exp_data, cmd_wdata);

  //////////////////////////////
  // AMO sequence at the ports
  //////////////////////////////
  // Locked read and write both go to rs1 as a full word
  a_amo: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_valid && is_amo) |-> (cmd_read == cmd_lock && cmd_addr == ea && cmd_size == size_word))
    else $error("FAILED %0t cmd_addr exp %h got %h, cmd_size exp %0d got %0d, read %b lock %b",
                $time, ea, cmd_addr, size_word, cmd_size, cmd_read, cmd_lock);
  // Issue retires only together with the commit
  a_amo_hs: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && is_amo && !mis) |-> (in_ready == (out_valid && out_ready)))
    else $error("FAILED %0t in_ready exp %b got %b", $time, out_valid && out_ready, in_ready);

  // Misaligned ops commit at once with no bus command
  a_mis: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && mis) |-> (!cmd_valid && out_valid && out_misalgn && out_err
      && in_ready == out_ready))
    else $error("FAILED %0t out_misalgn exp 1 got %b, out_valid exp 1 got %b, cmd_valid exp 0 got %b",
                $time, out_misalgn, out_valid, cmd_valid);

  //////////////////////////////
  // Commit flags
  //////////////////////////////
  a_commit: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (out_ld == (in_info.kind == kind_load) && out_stamo == is_stamo
      && out_badaddr == ea && ((is_amo && !mis) || out_wdat == '0)))
    else $error("FAILED %0t out_ld exp %b got %b, out_stamo exp %b got %b, out_badaddr exp %h got %h",
                $time, in_info.kind == kind_load, out_ld, is_stamo, out_stamo, ea, out_badaddr);
  // Aligned loads and stores carry no error and no old value
  a_ok: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !mis) |-> (!out_misalgn && (is_amo || (!out_err && !out_buserr))))
    else $error("FAILED %0t out_misalgn exp 0 got %b, out_err exp 0 got %b, out_buserr exp 0 got %b",
                $time, out_misalgn, out_err, out_buserr);

  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !in_valid |-> (!cmd_valid && !out_valid))
    else $error("Bus command or commit raised while no instruction was issued");
  // Only the AMO write may go out while commit is stalled
  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_valid && !out_ready) |-> (is_amo && !cmd_read && !cmd_lock))
    else $error("Load, store or locked read command issued while commit was stalled");
endmodule

bind agu_top agu_assertions agu_assertions_i (.*);

//--- test/agu_tb.sv
// Memory model covers 256 bytes; responses return in order 1 to 3 cycles after a command
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_tb;
  import agu_pkg::*;

  localparam int N_OPS = 200;
  localparam int LIMIT = N_OPS * 12;

  logic        clk, rst_n, in_valid, in_ready, out_valid, out_ready, cmd_valid, cmd_ready;
  logic        out_err, out_misalgn, out_ld, out_stamo, out_buserr;
  logic        cmd_read, cmd_lock, cmd_usign, rsp_valid, rsp_err;
  logic [31:0] in_rs1, in_rs2, in_imm, out_wdat, out_badaddr, cmd_addr, cmd_wdata, rsp_rdata;
  logic [3:0]  cmd_wmask;
  logic [1:0]  cmd_size;
  agu_info_t   in_info;
  logic [31:0] seed = 32'ha3f3_54db;
  logic [31:0] mem [64];
  int          due_q[$], cycles, amo_cnt;
  logic [32:0] rsp_q[$];
  logic [31:0] amo_old, amo_rs2, r;
  logic [3:0]  amo_op;
  logic        amo_err, amo_wr, passed, fail_shown;
  logic        out_ready_nxt, cmd_ready_nxt;

  agu_top agu_top_i (.*);

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // AMO result from the operation rules
  function automatic logic [31:0] amo_ref(logic [3:0] f, logic [31:0] a, logic [31:0] b);
    case (f)
      4'd1: return a + b;
      4'd2: return a & b;
      4'd3: return a | b;
      4'd4: return a ^ b;
      4'd5: return ($signed(a) < $signed(b)) ? b : a;
      4'd6: return ($signed(a) < $signed(b)) ? a : b;
      4'd7: return (a < b) ? b : a;
      4'd8: return (a < b) ? a : b;
      default: return b;
    endcase
  endfunction

  task automatic stop_run(string why);
    $display("%s", why);
    $display("** FAIL **");
    fail_shown = 1'b1;
    $fatal(1);
  endtask

  task automatic compare_value(string name, logic [31:0] exp, logic [31:0] got);
    if (exp !== got) begin
      stop_run($sformatf("FAILED %0t %s exp %h got %h", $time, name, exp, got));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Memory model and readies
  //////////////////////////////
  always begin
    @(negedge clk);
    if (rst_n) begin
      cycles++;
      if (cycles > LIMIT) stop_run("Timeout: operations did not finish in time");
      if (cmd_valid && cmd_ready) begin
        if (cmd_lock) begin
          amo_old = mem[cmd_addr[7:2]];
          amo_rs2 = in_rs2;
          amo_op  = in_info.body.amo;
          amo_cnt++;
          amo_err = (amo_cnt == 3);
        end else if (!cmd_read && in_info.kind == kind_amo) begin
          compare_value("cmd_wdata", amo_ref(amo_op, amo_old, amo_rs2), cmd_wdata);
          compare_value("cmd_wmask", amo_err ? 32'h0 : 32'hf, 32'(cmd_wmask));
          amo_wr = 1'b1;
        end
        rsp_q.push_back({cmd_lock && amo_err, mem[cmd_addr[7:2]]});
        due_q.push_back(cycles + 1 + int'(next_rand() % 3));
        for (int b = 0; b < 4; b++) begin
          if (cmd_wmask[b] && !cmd_read) mem[cmd_addr[7:2]][8*b +: 8] = cmd_wdata[8*b +: 8];
        end
      end
      // Commit of an aligned AMO, whose address is rs1
      if (out_valid && out_ready && in_info.kind == kind_amo && in_rs1[1:0] == 2'b00) begin
        if (!amo_wr) stop_run("AMO committed before its write command was issued");
        amo_wr = 1'b0;
        compare_value("out_wdat", amo_old, out_wdat);
        compare_value("out_buserr", 32'(amo_err), 32'(out_buserr));
        compare_value("out_err", 32'(amo_err), 32'(out_err));
      end
    end
    // Readies for the next cycle
    out_ready_nxt = next_rand() % 4 != 0;
    cmd_ready_nxt = next_rand() % 4 != 0;
    @(posedge clk);
    #1;
    out_ready = out_ready_nxt;
    cmd_ready = cmd_ready_nxt;
    rsp_valid = 1'b0;
    if (due_q.size() > 0 && due_q[0] <= cycles) begin
      void'(due_q.pop_front());
      {rsp_err, rsp_rdata} = rsp_q.pop_front();
      rsp_valid = 1'b1;
    end
  end

  //////////////////////////////
  // Issue stimulus
  //////////////////////////////
  initial begin
    {rst_n, in_valid, out_ready, cmd_ready, rsp_valid, rsp_err} = '0;
    {in_rs1, in_rs2, in_imm, rsp_rdata, in_info} = '0;
    {cycles, amo_cnt, amo_err, amo_wr, passed, fail_shown} = '0;
    for (int i = 0; i < 64; i++) mem[i] = 32'h9e37_79b9 * (i + 1);
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int n = 0; n < N_OPS; n++) begin
      r        = next_rand();
      in_rs1   = {24'h0, r[7:0] & (r[8] ? 8'hf0 : 8'hff)};
      in_imm   = {28'h0, r[12:9]};
      in_rs2   = next_rand();
      // Kind 0-2 load, 3-5 store, 6-7 AMO
      if (r[15:13] >= 3'd6) in_info = {kind_amo, 4'(r[19:16] % 9)};
      else in_info = {(r[15:13] < 3'd3) ? kind_load : kind_store, 1'b0, 2'(r[17:16] % 3), r[18]};
      in_valid = 1'b1;
      do @(negedge clk); while (!in_ready);
      @(posedge clk);
      #1 in_valid = r[20];
      if (!r[20]) @(posedge clk) #1;
    end
    in_valid = 1'b0;
    repeat (4) @(posedge clk);
    passed = 1'b1;
    $display("** PASS **");
    $finish;
  end

  final if (!passed && !fail_shown) $display("** FAIL **");
endmodule

//--- verilog/agu_decode.sv
// Purely combinational; the reserved kind code decodes to no load, store or AMO
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_decode (
  input  agu_pkg::agu_info_t   info,
  input  logic [`AGU_XLEN-1:0] rs1,
  input  logic [`AGU_XLEN-1:0] rs2,
  input  logic [`AGU_XLEN-1:0] imm,
  agu_op_if.decode             op
);
  import agu_pkg::*;
  import mem_pkg::*;

  // Class from the kind field
  assign op.is_load  = (info.kind == kind_load);
  assign op.is_store = (info.kind == kind_store);
  assign op.is_amo   = (info.kind == kind_amo);

  // Body read in the view the kind selects
  always_comb begin
    if (op.is_amo) begin
      // AMO is always a full signed word
      op.size   = size_word;
      op.usign  = 1'b0;
      op.amo_op = info.body.amo;
    end else begin
      op.size   = info.body.ls.size;
      op.usign  = info.body.ls.usign;
      // Unused for loads and stores
      op.amo_op = amo_swap;
    end
  end

  assign op.base   = rs1;
  // AMO address is rs1 with no offset
  assign op.offset = op.is_amo ? '0 : imm;
  assign op.rs2    = rs2;

endmodule

//--- verilog/agu_exec_if.sv
// Execute to result link; buffers hold only one AMO at a time
`timescale 1ns/1ps
`include "agu_macros.svh"

interface agu_exec_if;
  import mem_pkg::*;

  // Combinational address path
  logic [`AGU_ADDR_W-1:0] addr;
  logic                   misalgn;
  // Registered AMO sequence
  amo_state_t             state;
  logic [`AGU_XLEN-1:0]   rdbuf;
  logic [`AGU_XLEN-1:0]   newbuf;
  logic                   buserr;
  // Handshake events back from result
  logic                   cmd_fire;
  logic                   issue_fire;

  modport exec (
    output addr, misalgn, state, rdbuf, newbuf, buserr,
    input  cmd_fire, issue_fire
  );

  modport result (
    input  addr, misalgn, state, rdbuf, newbuf, buserr,
    output cmd_fire, issue_fire
  );

endinterface

//--- verilog/agu_execute.sv
// Responses must return in command order; one AMO in flight, older responses are skipped
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_execute (
  input  logic                 clk,
  input  logic                 rst_n,
  agu_op_if.exec               op,
  agu_exec_if.exec             ex,
  input  logic                 in_valid,
  input  logic                 rsp_valid,
  input  logic                 rsp_err,
  input  logic [`AGU_XLEN-1:0] rsp_rdata
);
  import agu_pkg::*;
  import mem_pkg::*;

  amo_state_t           state_r;
  amo_state_t           state_nxt;
  logic [`AGU_XLEN-1:0] sum;
  logic [`AGU_XLEN-1:0] alu_res;
  logic [`AGU_XLEN-1:0] rdbuf_r;
  logic [`AGU_XLEN-1:0] newbuf_r;
  logic                 err_r;
  logic [3:0]           pend_r;
  logic                 amo_start;
  logic                 rsp_amo;
  logic                 lt_s;
  logic                 lt_u;

  //////////////////////////////
  // Address and alignment
  //////////////////////////////
  assign sum     = op.base + op.offset;
  assign ex.addr = sum[`AGU_ADDR_W-1:0];

  always_comb begin
    case (op.size)
      size_half: ex.misalgn = ex.addr[0];
      size_word: ex.misalgn = |ex.addr[1:0];
      default:   ex.misalgn = 1'b0;
    endcase
  end

  // Outstanding bus responses
  // The AMO response is the last one pending
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_r <= '0;
    end else if (ex.cmd_fire != rsp_valid) begin
      pend_r <= ex.cmd_fire ? pend_r + 4'd1 : pend_r - 4'd1;
    end
  end

  assign rsp_amo   = rsp_valid & (pend_r == 4'd1);
  // Locked read accepted for an aligned AMO
  assign amo_start = in_valid & op.is_amo & ~ex.misalgn & ex.cmd_fire;

  //////////////////////////////
  // AMO sequence
  //////////////////////////////
  always_comb begin
    state_nxt = state_r;
    case (state_r)
      st_idle:        if (amo_start) state_nxt = st_first;
      st_first:       if (rsp_amo) state_nxt = st_alu;
      // ALU result captured in one cycle
      st_alu:         state_nxt = st_ready;
      st_ready:       state_nxt = st_wait_second;
      st_wait_second: if (ex.cmd_fire) state_nxt = st_second;
      st_second:      if (rsp_amo) state_nxt = st_wbck;
      // Leave once commit takes the AMO
      st_wbck:        if (ex.issue_fire) state_nxt = st_idle;
      default:        state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_r  <= st_idle;
      rdbuf_r  <= '0;
      newbuf_r <= '0;
      err_r    <= 1'b0;
    end else begin
      state_r <= state_nxt;
      // Old memory value and read error
      if (state_r == st_first && rsp_amo) begin
        rdbuf_r <= rsp_rdata;
        err_r   <= rsp_err;
      end
      // Write error merged into the same bit
      if (state_r == st_second && rsp_amo) begin
        err_r <= err_r | rsp_err;
      end
      if (state_r == st_alu) begin
        newbuf_r <= alu_res;
      end
    end
  end

  //////////////////////////////
  // AMO ALU
  //////////////////////////////
  assign lt_s = $signed(rdbuf_r) < $signed(op.rs2);
  assign lt_u = rdbuf_r < op.rs2;

  always_comb begin
    case (op.amo_op)
      amo_add:  alu_res = rdbuf_r + op.rs2;
      amo_and:  alu_res = rdbuf_r & op.rs2;
      amo_or:   alu_res = rdbuf_r | op.rs2;
      amo_xor:  alu_res = rdbuf_r ^ op.rs2;
      amo_max:  alu_res = lt_s ? op.rs2 : rdbuf_r;
      amo_min:  alu_res = lt_s ? rdbuf_r : op.rs2;
      amo_maxu: alu_res = lt_u ? op.rs2 : rdbuf_r;
      amo_minu: alu_res = lt_u ? rdbuf_r : op.rs2;
      // Swap writes rs2 as is
      default:  alu_res = op.rs2;
    endcase
  end

  assign ex.state  = state_r;
  assign ex.rdbuf  = rdbuf_r;
  assign ex.newbuf = newbuf_r;
  assign ex.buserr = err_r;

endmodule

//--- verilog/agu_op_if.sv
// Decoded operation; every field follows the issue inputs and must stay stable until in_ready
`timescale 1ns/1ps
`include "agu_macros.svh"

interface agu_op_if;
  import mem_pkg::*;
  import agu_pkg::*;

  // Operation class
  logic                 is_load;
  logic                 is_store;
  logic                 is_amo;
  // Access attributes
  mem_size_t            size;
  logic                 usign;
  amo_op_t              amo_op;
  // Address operands and store source
  logic [`AGU_XLEN-1:0] base;
  logic [`AGU_XLEN-1:0] offset;
  logic [`AGU_XLEN-1:0] rs2;

  modport decode (
    output is_load, is_store, is_amo, size, usign, amo_op, base, offset, rs2
  );

  modport exec (input is_amo, size, amo_op, base, offset, rs2);

  modport result (input is_load, is_store, is_amo, size, usign, rs2);

endinterface

//--- verilog/agu_pkg.sv
// Instruction-side types; the info word is 6 bits and its body has two views by kind
package agu_pkg;

  // Memory instruction class
  typedef enum logic [1:0] {
    kind_load  = 2'd0,
    kind_store = 2'd1,
    kind_amo   = 2'd2
  } agu_kind_t;

  // AMO operations
  typedef enum logic [3:0] {
    amo_swap = 4'd0,
    amo_add  = 4'd1,
    amo_and  = 4'd2,
    amo_or   = 4'd3,
    amo_xor  = 4'd4,
    amo_max  = 4'd5,
    amo_min  = 4'd6,
    amo_maxu = 4'd7,
    amo_minu = 4'd8
  } amo_op_t;

  // Load/store view of the body
  typedef struct packed {
    logic               rsvd;
    mem_pkg::mem_size_t size;
    logic               usign;
  } ls_fields_t;

  // Body bits, read as ls for loads and stores and as amo for AMOs
  typedef union packed {
    ls_fields_t ls;
    amo_op_t    amo;
  } agu_body_u;

  typedef struct packed {
    agu_kind_t kind;
    agu_body_u body;
  } agu_info_t;

endpackage

//--- verilog/agu_result.sv
// Combinational only; byte lanes assume four lanes and issue fields held until in_ready
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_result (
  agu_op_if.result               op,
  agu_exec_if.result             ex,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic                   out_ready,
  input  logic                   cmd_ready,
  output logic                   out_valid,
  output logic                   cmd_valid,
  output logic                   cmd_read,
  output logic                   cmd_lock,
  output logic                   cmd_usign,
  output logic [`AGU_ADDR_W-1:0] cmd_addr,
  output mem_pkg::mem_size_t     cmd_size,
  output logic [`AGU_XLEN-1:0]   cmd_wdata,
  output logic [`AGU_LANES-1:0]  cmd_wmask,
  output logic [`AGU_XLEN-1:0]   out_wdat,
  output logic [`AGU_ADDR_W-1:0] out_badaddr,
  output logic                   out_err,
  output logic                   out_misalgn,
  output logic                   out_ld,
  output logic                   out_stamo,
  output logic                   out_buserr
);
  import mem_pkg::*;

  localparam logic [`AGU_LANES-1:0] mask_b = 1;
  localparam logic [`AGU_LANES-1:0] mask_h = 3;
  localparam logic [`AGU_LANES-1:0] mask_w = '1;

  logic                  is_idle;
  logic                  is_wait2;
  logic                  is_wbck;
  logic                  any_op;
  logic                  misalgn_op;
  logic                  algn_ldst;
  logic                  algn_amo;
  logic [`AGU_XLEN-1:0]  st_wdata;
  logic [`AGU_LANES-1:0] st_wmask;

  assign is_idle    = (ex.state == st_idle);
  assign is_wait2   = (ex.state == st_wait_second);
  assign is_wbck    = (ex.state == st_wbck);
  assign any_op     = op.is_load | op.is_store | op.is_amo;
  assign misalgn_op = any_op & ex.misalgn;
  assign algn_ldst  = (op.is_load | op.is_store) & ~ex.misalgn;
  assign algn_amo   = op.is_amo & ~ex.misalgn;

  //////////////////////////////
  // Handshakes
  //////////////////////////////
  // Aligned load/store goes to bus and commit in the same cycle
  assign cmd_valid = (algn_ldst & in_valid & out_ready)
                   | (algn_amo & ((is_idle & in_valid & out_ready) | is_wait2));
  // Misaligned ops commit at once without a bus command
  assign out_valid = (in_valid & ((algn_ldst & cmd_ready) | misalgn_op))
                   | (algn_amo & is_wbck);
  // AMO retires only from wbck
  assign in_ready  = algn_amo   ? (is_wbck & out_ready) :
                     misalgn_op ? out_ready : (cmd_ready & out_ready);

  assign ex.cmd_fire   = cmd_valid & cmd_ready;
  assign ex.issue_fire = in_valid & in_ready & algn_amo;

  //////////////////////////////
  // Bus command
  //////////////////////////////
  // Read for loads and the first AMO step, locked for the AMO read
  assign cmd_read  = op.is_load | (op.is_amo & is_idle);
  assign cmd_lock  = algn_amo & is_idle;
  assign cmd_usign = op.usign;
  assign cmd_addr  = ex.addr;
  assign cmd_size  = op.size;

  // Store data copied to every lane of its size
  always_comb begin
    case (op.size)
      size_byte: begin
        st_wdata = {(`AGU_LANES){op.rs2[7:0]}};
        st_wmask = mask_b << ex.addr[1:0];
      end
      size_half: begin
        st_wdata = {(`AGU_LANES / 2){op.rs2[15:0]}};
        st_wmask = mask_h << {ex.addr[1], 1'b0};
      end
      default: begin
        st_wdata = op.rs2;
        st_wmask = mask_w;
      end
    endcase
  end

  // AMO write carries the ALU result
  // No bytes written after a read error
  assign cmd_wdata = op.is_amo ? ex.newbuf : st_wdata;
  assign cmd_wmask = op.is_amo ? (ex.buserr ? '0 : mask_w) : st_wmask;

  // Commit flags
  assign out_wdat    = algn_amo ? ex.rdbuf : '0;
  assign out_badaddr = ex.addr;
  assign out_misalgn = misalgn_op;
  assign out_buserr  = algn_amo & ex.buserr;
  assign out_err     = out_buserr | out_misalgn;
  assign out_ld      = op.is_load;
  assign out_stamo   = op.is_store | op.is_amo;

endmodule

//--- verilog/agu_top.sv
// Plain-port AGU; inputs held until in_ready, bus responses in order, response always taken
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Issue side
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [`AGU_XLEN-1:0]   in_rs1,
  input  logic [`AGU_XLEN-1:0]   in_rs2,
  input  logic [`AGU_XLEN-1:0]   in_imm,
  input  agu_pkg::agu_info_t     in_info,
  // Commit side
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [`AGU_XLEN-1:0]   out_wdat,
  output logic                   out_err,
  output logic                   out_misalgn,
  output logic                   out_ld,
  output logic                   out_stamo,
  output logic                   out_buserr,
  output logic [`AGU_ADDR_W-1:0] out_badaddr,
  // Memory command
  output logic                   cmd_valid,
  input  logic                   cmd_ready,
  output logic [`AGU_ADDR_W-1:0] cmd_addr,
  output logic                   cmd_read,
  output logic [`AGU_XLEN-1:0]   cmd_wdata,
  output logic [`AGU_LANES-1:0]  cmd_wmask,
  output logic                   cmd_lock,
  output mem_pkg::mem_size_t     cmd_size,
  output logic                   cmd_usign,
  // Memory response
  input  logic                   rsp_valid,
  input  logic                   rsp_err,
  input  logic [`AGU_XLEN-1:0]   rsp_rdata
);

  agu_op_if   op_bus ();
  agu_exec_if ex_bus ();

  agu_decode agu_decode_i (
    .info (in_info),
    .rs1  (in_rs1),
    .rs2  (in_rs2),
    .imm  (in_imm),
    .op   (op_bus)
  );

  // Remaining ports match top-level names
  agu_execute agu_execute_i (.op(op_bus), .ex(ex_bus), .*);

  agu_result agu_result_i (.op(op_bus), .ex(ex_bus), .*);

endmodule

//--- verilog/mem_pkg.sv
// Memory-side types; size codes follow the bus size field and stay within 2 bits
package mem_pkg;

  // Access size on the command bus
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_t;

  // AMO read-modify-write sequence
  typedef enum logic [2:0] {
    st_idle        = 3'd0,
    // Locked read issued, waiting for its response
    st_first       = 3'd1,
    // Write data ready, waiting for the bus to take it
    st_wait_second = 3'd2,
    // Write issued, waiting for its response
    st_second      = 3'd3,
    st_alu         = 3'd4,
    st_ready       = 3'd5,
    // Old value held for commit
    st_wbck        = 3'd6
  } amo_state_t;

endpackage
